//--- design/spi_hub_consts.svh
`ifndef SPI_HUB_CONSTS_SVH
`define SPI_HUB_CONSTS_SVH

// Number of independent SPI channels served by the hub.
`define SPI_NUM_CH 4

// One command frame is rw, a register address and a data byte.
`define SPI_CMD_WIDTH 12

`define SPI_READ_WIDTH 8

// System clocks per sclk half period, so one sclk bit takes twice this.
`define SPI_HALF_PERIOD 2

`endif

//--- design/spi_hub_pkg.sv
`include "spi_hub_consts.svh"

package spi_hub_pkg;

  // Bit 11 is rw, the address sits between rw and the data byte.
  typedef struct packed {
    logic                                           rw;
    logic [`SPI_CMD_WIDTH-`SPI_READ_WIDTH-2:0]      addr;
    logic [`SPI_READ_WIDTH-1:0]                     data;
  } spi_cmd_t;

  typedef struct packed {
    logic [$clog2(`SPI_NUM_CH)-1:0] ch;
    spi_cmd_t                       cmd;
  } spi_req_t;

  typedef struct packed {
    logic [$clog2(`SPI_NUM_CH)-1:0] ch;
    logic [`SPI_READ_WIDTH-1:0]     data;
  } spi_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT_CMD,
    SHIFT_READ,
    FINISH
  } spi_state_e;

endpackage

//--- design/spi_cmd_router.sv
`timescale 1ns/1ps
`include "spi_hub_consts.svh"

module spi_cmd_router (
  input  logic                    clk,
  input  logic                    rst_n,
  input  spi_hub_pkg::spi_req_t   req,
  input  logic                    req_vld,
  input  logic [`SPI_NUM_CH-1:0]  busy,
  output spi_hub_pkg::spi_cmd_t   ch_cmd [`SPI_NUM_CH],
  output logic [`SPI_NUM_CH-1:0]  start,
  output logic                    cmd_drop
);

  logic [`SPI_NUM_CH-1:0] claimed;
  logic                   accept;

  // A channel whose start is still in flight has not raised busy yet,
  // so it counts as taken for one more cycle.
  assign claimed = busy | start;
  assign accept  = req_vld && !claimed[req.ch];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      start    <= '0;
      cmd_drop <= 1'b0;
    end
    else
    begin
      start    <= '0;
      cmd_drop <= req_vld && claimed[req.ch];
      if (accept)
        start[req.ch] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      ch_cmd[req.ch] <= req.cmd;
  end

endmodule

//--- design/spi_master.sv
`timescale 1ns/1ps
`include "spi_hub_consts.svh"

module spi_master (
  input  logic                       clk,
  input  logic                       rst_n,
  input  spi_hub_pkg::spi_cmd_t      cmd,
  input  logic                       start,
  output logic                       busy,
  output logic                       sclk,
  output logic                       cs_n,
  output logic                       mosi,
  input  logic                       miso,
  output logic                       rd_vld,
  output logic [`SPI_READ_WIDTH-1:0] rd_data
);

  import spi_hub_pkg::*;

  localparam int HALF_W = ($clog2(`SPI_HALF_PERIOD) > 0) ? $clog2(`SPI_HALF_PERIOD) : 1;
  localparam int BIT_W  = $clog2(`SPI_CMD_WIDTH);

  spi_state_e                 state;
  spi_state_e                 state_nxt;
  logic [HALF_W-1:0]          half_cnt;
  logic [BIT_W-1:0]           bit_cnt;
  logic [`SPI_CMD_WIDTH-1:0]  cmd_shift;
  logic [`SPI_READ_WIDTH-1:0] rd_shift;
  logic                       rd_mode;
  logic                       tick;
  logic                       sclk_rise;
  logic                       sclk_fall;
  logic                       cmd_last;
  logic                       rd_last;

  // The divider ends a half period on tick; sclk toggles there.
  assign tick      = (half_cnt == HALF_W'(`SPI_HALF_PERIOD - 1));
  assign sclk_rise = tick && !sclk;
  assign sclk_fall = tick && sclk;
  assign cmd_last  = (bit_cnt == BIT_W'(`SPI_CMD_WIDTH - 1));
  assign rd_last   = (bit_cnt == BIT_W'(`SPI_READ_WIDTH - 1));

  assign busy    = (state != IDLE);
  assign rd_data = rd_shift;

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
        if (start)
          state_nxt = SHIFT_CMD;
      SHIFT_CMD:
        if (sclk_fall && cmd_last)
          state_nxt = rd_mode ? SHIFT_READ : FINISH;
      SHIFT_READ:
        if (sclk_fall && rd_last)
          state_nxt = FINISH;
      FINISH:
        if (tick)
          state_nxt = IDLE;
      default:
        state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      half_cnt <= '0;
      bit_cnt  <= '0;
      sclk     <= 1'b0;
      cs_n     <= 1'b1;
      mosi     <= 1'b0;
      rd_mode  <= 1'b0;
      rd_vld   <= 1'b0;
    end
    else
    begin
      state  <= state_nxt;
      rd_vld <= 1'b0;
      if (state == IDLE)
      begin
        half_cnt <= '0;
        bit_cnt  <= '0;
        if (start)
        begin
          // First bit is on mosi as soon as cs_n falls.
          cs_n    <= 1'b0;
          mosi    <= cmd.rw;
          rd_mode <= !cmd.rw;
        end
      end
      else
      begin
        half_cnt <= tick ? '0 : half_cnt + 1'b1;
        if (state != FINISH && tick)
          sclk <= !sclk;
        if (sclk_fall)
        begin
          if ((state == SHIFT_CMD && cmd_last) || (state == SHIFT_READ && rd_last))
            bit_cnt <= '0;
          else
            bit_cnt <= bit_cnt + 1'b1;
          if (state == SHIFT_CMD && !cmd_last)
            mosi <= cmd_shift[`SPI_CMD_WIDTH-2];
          else
            mosi <= 1'b0;
        end
        if (state == FINISH && tick)
        begin
          cs_n   <= 1'b1;
          rd_vld <= rd_mode;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == IDLE && start)
      cmd_shift <= cmd;
    else if (state == SHIFT_CMD && sclk_fall)
      cmd_shift <= {cmd_shift[`SPI_CMD_WIDTH-2:0], 1'b0};
    // The peripheral updates miso after the falling edge, so sample on the rising one.
    if (state == SHIFT_READ && sclk_rise)
      rd_shift <= {rd_shift[`SPI_READ_WIDTH-2:0], miso};
  end

endmodule

//--- design/spi_rsp_arbiter.sv
`timescale 1ns/1ps
`include "spi_hub_consts.svh"

module spi_rsp_arbiter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`SPI_NUM_CH-1:0]     rd_vld,
  input  logic [`SPI_READ_WIDTH-1:0] rd_data [`SPI_NUM_CH],
  output spi_hub_pkg::spi_rsp_t      rsp,
  output logic                       rsp_vld
);

  localparam int CH_W = $clog2(`SPI_NUM_CH);

  logic [`SPI_NUM_CH-1:0]     pend_vld;
  logic [`SPI_READ_WIDTH-1:0] pend_data [`SPI_NUM_CH];
  logic [`SPI_NUM_CH-1:0]     cand_vld;
  logic [`SPI_READ_WIDTH-1:0] cand_data [`SPI_NUM_CH];
  logic [CH_W-1:0]            rr_ptr;
  logic [CH_W-1:0]            grant;
  logic                       grant_vld;

  // A fresh result competes in the same cycle it arrives.
  assign cand_vld = pend_vld | rd_vld;

  always_comb
  begin
    for (int i = 0; i < `SPI_NUM_CH; i++)
      cand_data[i] = pend_vld[i] ? pend_data[i] : rd_data[i];
  end

  always_comb
  begin
    int idx;
    grant     = rr_ptr;
    grant_vld = 1'b0;
    // Walk backwards so the channel closest to the pointer wins.
    for (int k = `SPI_NUM_CH - 1; k >= 0; k--)
    begin
      idx = (int'(rr_ptr) + k) % `SPI_NUM_CH;
      if (cand_vld[idx])
      begin
        grant     = CH_W'(idx);
        grant_vld = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pend_vld <= '0;
      rr_ptr   <= '0;
      rsp_vld  <= 1'b0;
    end
    else
    begin
      rsp_vld <= grant_vld;
      if (grant_vld)
        rr_ptr <= CH_W'((int'(grant) + 1) % `SPI_NUM_CH);
      for (int i = 0; i < `SPI_NUM_CH; i++)
      begin
        if (grant_vld && grant == CH_W'(i))
          pend_vld[i] <= 1'b0;
        else if (rd_vld[i])
          pend_vld[i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < `SPI_NUM_CH; i++)
      if (rd_vld[i])
        pend_data[i] <= rd_data[i];
    rsp.ch   <= grant;
    rsp.data <= cand_data[grant];
  end

endmodule

//--- design/spi_hub.sv
`timescale 1ns/1ps
`include "spi_hub_consts.svh"

module spi_hub (
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_hub_pkg::spi_req_t  req,
  input  logic                   req_vld,
  output logic                   cmd_drop,
  output logic [`SPI_NUM_CH-1:0] busy,
  output logic [`SPI_NUM_CH-1:0] sclk,
  output logic [`SPI_NUM_CH-1:0] cs_n,
  output logic [`SPI_NUM_CH-1:0] mosi,
  input  logic [`SPI_NUM_CH-1:0] miso,
  output spi_hub_pkg::spi_rsp_t  rsp,
  output logic                   rsp_vld
);

  import spi_hub_pkg::*;

  spi_cmd_t                   ch_cmd [`SPI_NUM_CH];
  logic [`SPI_NUM_CH-1:0]     start;
  logic [`SPI_NUM_CH-1:0]     rd_vld;
  logic [`SPI_READ_WIDTH-1:0] rd_data [`SPI_NUM_CH];

  spi_cmd_router u_router (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .req_vld  (req_vld),
    .busy     (busy),
    .ch_cmd   (ch_cmd),
    .start    (start),
    .cmd_drop (cmd_drop)
  );

  for (genvar i = 0; i < `SPI_NUM_CH; i++)
  begin : g_ch
    spi_master u_master (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd     (ch_cmd[i]),
      .start   (start[i]),
      .busy    (busy[i]),
      .sclk    (sclk[i]),
      .cs_n    (cs_n[i]),
      .mosi    (mosi[i]),
      .miso    (miso[i]),
      .rd_vld  (rd_vld[i]),
      .rd_data (rd_data[i])
    );
  end

  spi_rsp_arbiter u_arbiter (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_vld  (rd_vld),
    .rd_data (rd_data),
    .rsp     (rsp),
    .rsp_vld (rsp_vld)
  );

endmodule

//--- tests/spi_clk_gen.sv
`timescale 1ns/1ps

module spi_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset is released on a falling edge, away from the edge the DUT samples on.
  initial
  begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- tests/spi_slave_model.sv
`timescale 1ns/1ps
`include "spi_hub_consts.svh"

module spi_slave_model #(
  parameter int CH = 0
) (
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  logic [7:0]                regs [8];
  logic [`SPI_CMD_WIDTH-1:0] frame = '0;
  logic                      miso_q = 1'b0;
  int                        bit_cnt = 0;

  assign miso = miso_q;

  // Power-up contents follow the same pattern as the testbench reference model.
  initial
  begin
    for (int a = 0; a < 8; a++)
      regs[a] = 8'((CH * 37 + a * 11) ^ 'h5c);
  end

  always @(posedge sclk or posedge cs_n)
  begin
    if (cs_n)
      bit_cnt <= 0;
    else
    begin
      // The frame stops shifting once the command is in, so the read phase still sees it.
      if (bit_cnt < `SPI_CMD_WIDTH)
        frame <= {frame[`SPI_CMD_WIDTH-2:0], mosi};
      bit_cnt <= bit_cnt + 1;
      // On the last command bit, frame holds rw, addr and the upper seven data bits.
      if (bit_cnt == `SPI_CMD_WIDTH - 1 && frame[10])
        regs[frame[9:7]] <= {frame[6:0], mosi};
    end
  end

  // Read data goes out MSB first, one bit after each falling edge past the command.
  always @(negedge sclk or posedge cs_n)
  begin
    if (cs_n)
      miso_q <= 1'b0;
    else if (!frame[11] && bit_cnt >= `SPI_CMD_WIDTH && bit_cnt < `SPI_CMD_WIDTH + 8)
      miso_q <= regs[frame[10:8]][3'(`SPI_CMD_WIDTH + 7 - bit_cnt)];
  end

endmodule

//--- tests/spi_hub_assert.sv
`timescale 1ns/1ps
`include "spi_hub_consts.svh"

module spi_hub_assert (
  input logic                   clk,
  input logic                   rst_n,
  input logic [`SPI_NUM_CH-1:0] busy,
  input logic [`SPI_NUM_CH-1:0] sclk,
  input logic [`SPI_NUM_CH-1:0] cs_n,
  input logic [`SPI_NUM_CH-1:0] mosi,
  input spi_hub_pkg::spi_rsp_t  rsp,
  input logic                   rsp_vld
);

  for (genvar i = 0; i < `SPI_NUM_CH; i++)
  begin : g_ch
    idle_not_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
      cs_n[i] |-> !busy[i])
      else $error("channel %0d reports busy while cs_n is high", i);

    idle_sclk_low_a: assert property (@(posedge clk) disable iff (!rst_n)
      cs_n[i] |-> !sclk[i])
      else $error("channel %0d has sclk high while cs_n is high", i);

    // Data may only move while sclk is low.
    mosi_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
      sclk[i] |-> $stable(mosi[i]))
      else $error("channel %0d changed mosi while sclk was high", i);
  end

  rsp_single_a: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_vld && $past(rsp_vld)) |-> (rsp.ch != $past(rsp.ch)))
    else $error("rsp_vld held for two cycles on channel %0d", rsp.ch);

endmodule

bind spi_hub spi_hub_assert u_assert (
  .clk     (clk),
  .rst_n   (rst_n),
  .busy    (busy),
  .sclk    (sclk),
  .cs_n    (cs_n),
  .mosi    (mosi),
  .rsp     (rsp),
  .rsp_vld (rsp_vld)
);

//--- tests/spi_hub_tb.sv
`timescale 1ns/1ps
`include "spi_hub_consts.svh"

module spi_hub_tb;

  import spi_hub_pkg::*;

  localparam int CH_W       = $clog2(`SPI_NUM_CH);
  localparam int WR_CLKS    = 50;
  localparam int RD_CLKS    = 82;
  localparam int N_RANDOM   = 200;
  localparam int N_REQ      = 24 + N_RANDOM;
  localparam int LIMIT_CLKS = N_REQ * 100 + 1000;

  logic                   clk;
  logic                   rst_n;
  spi_req_t               req;
  logic                   req_vld;
  logic                   cmd_drop;
  logic [`SPI_NUM_CH-1:0] busy;
  logic [`SPI_NUM_CH-1:0] sclk;
  logic [`SPI_NUM_CH-1:0] cs_n;
  logic [`SPI_NUM_CH-1:0] mosi;
  wire  [`SPI_NUM_CH-1:0] miso;
  spi_rsp_t               rsp;
  logic                   rsp_vld;

  logic [7:0]  model [`SPI_NUM_CH][8];
  logic [7:0]  exp_q [`SPI_NUM_CH][$];
  int          free_at [`SPI_NUM_CH];
  int          cycle = 0;
  int          mismatches = 0;
  int          other_errors = 0;
  int          checked = 0;
  int          drops_expected = 0;
  int          drops_seen = 0;

  spi_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  for (genvar i = 0; i < `SPI_NUM_CH; i++)
  begin : g_slave
    spi_slave_model #(.CH(i)) u_slave (
      .sclk (sclk[i]),
      .cs_n (cs_n[i]),
      .mosi (mosi[i]),
      .miso (miso[i])
    );
  end

  spi_hub u_spi_hub (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .req_vld  (req_vld),
    .cmd_drop (cmd_drop),
    .busy     (busy),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .miso     (miso),
    .rsp      (rsp),
    .rsp_vld  (rsp_vld)
  );

  // Register file model of the peripherals; writes update it, reads return it.
  function automatic logic [7:0] expected_read(input spi_req_t r);
    if (r.cmd.rw)
      model[r.ch][r.cmd.addr] = r.cmd.data;
    return model[r.ch][r.cmd.addr];
  endfunction

  // Called on a falling edge. A request to a busy channel skips the occupancy wait.
  task automatic issue(input logic [CH_W-1:0] ch, input logic rw, input logic [2:0] addr,
                       input logic [7:0] data, input logic to_busy);
    spi_req_t r;
    r.ch       = ch;
    r.cmd.rw   = rw;
    r.cmd.addr = addr;
    r.cmd.data = data;
    if (to_busy)
      drops_expected++;
    else
    begin
      while (cycle < free_at[ch])
        @(negedge clk);
      assert (!busy[ch])
      else
      begin
        $display("ERROR: channel %0d is still busy when its frame should have ended", ch);
        other_errors++;
      end
      if (!rw)
        exp_q[ch].push_back(expected_read(r));
      else
        void'(expected_read(r));
      // Router register, then the frame itself.
      free_at[ch] = cycle + (rw ? WR_CLKS : RD_CLKS) + 2;
    end
    req     = r;
    req_vld = 1'b1;
    @(negedge clk);
    req_vld = 1'b0;
  endtask

  always @(posedge clk)
    cycle <= cycle + 1;

  always @(posedge clk)
  begin
    if (rst_n && cmd_drop)
    begin
      drops_seen++;
      assert (drops_seen <= drops_expected)
      else
      begin
        $display("ERROR: cmd_drop pulsed for a request sent to an idle channel");
        other_errors++;
      end
    end
    if (rst_n && rsp_vld)
    begin
      assert (exp_q[rsp.ch].size() > 0)
      else
      begin
        $display("ERROR: response on channel %0d with no read outstanding", rsp.ch);
        other_errors++;
      end
      if (exp_q[rsp.ch].size() > 0)
      begin
        assert (rsp.data == exp_q[rsp.ch][0])
        else
        begin
          $display("mismatch at %0t: channel %0d returned 0x%02h, expected 0x%02h",
                   $time, rsp.ch, rsp.data, exp_q[rsp.ch][0]);
          mismatches++;
        end
        void'(exp_q[rsp.ch].pop_front());
        checked++;
      end
    end
  end

  initial
  begin
    logic [CH_W-1:0] ch;
    logic [2:0]      addr;
    req      = '0;
    req_vld  = 1'b0;
    void'($urandom(32'h24eb));
    for (int c = 0; c < `SPI_NUM_CH; c++)
    begin
      free_at[CH_W'(c)] = 0;
      for (int a = 0; a < 8; a++)
        model[CH_W'(c)][3'(a)] = 8'((c * 37 + a * 11) ^ 'h5c);
    end
    wait (rst_n);
    @(negedge clk);
    for (int c = 0; c < `SPI_NUM_CH; c++)
    begin
      issue(CH_W'(c), 1'b1, 3'(c + 1), 8'($urandom), 1'b0);
      issue(CH_W'(c), 1'b0, 3'(c + 1), 8'h00, 1'b0);
    end
    for (int a = 4; a < 8; a++)
      issue(CH_W'(2), 1'b1, 3'(a), 8'($urandom), 1'b0);
    for (int a = 7; a >= 4; a--)
      issue(CH_W'(2), 1'b0, 3'(a), 8'h00, 1'b0);
    // All four channels read at once.
    for (int c = 0; c < `SPI_NUM_CH; c++)
      while (cycle < free_at[CH_W'(c)])
        @(negedge clk);
    for (int c = 0; c < `SPI_NUM_CH; c++)
      issue(CH_W'(c), 1'b0, 3'(c + 1), 8'h00, 1'b0);
    // The second write arrives while channel 1 is still starting its frame.
    // The third one lands in the middle of it.
    issue(CH_W'(1), 1'b1, 3'd6, 8'hc3, 1'b0);
    issue(CH_W'(1), 1'b1, 3'd6, 8'h3c, 1'b1);
    repeat (10) @(negedge clk);
    assert (busy[1])
    else
    begin
      $display("ERROR: channel 1 is not busy in the middle of its frame");
      other_errors++;
    end
    issue(CH_W'(1), 1'b1, 3'd6, 8'h5a, 1'b1);
    issue(CH_W'(1), 1'b0, 3'd6, 8'h00, 1'b0);
    for (int n = 0; n < N_RANDOM; n++)
    begin
      ch   = CH_W'($urandom % `SPI_NUM_CH);
      addr = 3'($urandom);
      issue(ch, 1'($urandom % 2), addr, 8'($urandom), 1'b0);
    end
    for (int c = 0; c < `SPI_NUM_CH; c++)
      while (cycle < free_at[CH_W'(c)] + 10)
        @(negedge clk);
    for (int c = 0; c < `SPI_NUM_CH; c++)
      assert (exp_q[CH_W'(c)].size() == 0)
      else
      begin
        $display("ERROR: channel %0d never returned %0d expected read responses",
                 c, exp_q[CH_W'(c)].size());
        other_errors++;
      end
    assert (drops_seen == drops_expected)
    else
    begin
      $display("ERROR: saw %0d dropped commands, expected %0d", drops_seen, drops_expected);
      other_errors++;
    end
    $display("Errors: %0d mismatches, %0d other failures, %0d responses checked",
             mismatches, other_errors, checked);
    if (mismatches == 0 && other_errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    repeat (LIMIT_CLKS) @(posedge clk);
    $display("ERROR: timeout after %0d clocks, the tests did not finish", LIMIT_CLKS);
    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- spi_hub.f
+incdir+design
design/spi_hub_pkg.sv
design/spi_cmd_router.sv
design/spi_master.sv
design/spi_rsp_arbiter.sv
design/spi_hub.sv
tests/spi_clk_gen.sv
tests/spi_slave_model.sv
tests/spi_hub_assert.sv
tests/spi_hub_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and passes only on the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module spi_hub_tb -f spi_hub.f -o spi_hub_sim \
  && ./obj_dir/spi_hub_sim | tee /dev/stderr | grep -x "TESTBENCH PASSED" > /dev/null \
  && echo "Simulation passed." \
  || { echo "Simulation did not pass." >&2; exit 1; }
